//--- hdl/fabric_pkg.sv
package fabric_pkg;

    localparam int LUT_K = 4;
    localparam int LUT_BITS = 1 << LUT_K; // one truth table entry per input pattern
    localparam int NUM_SIDES = 4;

    // side order used by every block, left side sits at the low bits
    localparam int SIDE_LEFT = 0;
    localparam int SIDE_TOP = 1;
    localparam int SIDE_RIGHT = 2;
    localparam int SIDE_BOTTOM = 3;

    // connector outputs choose from zero plus both sides' pins
    function automatic int cx_sel_width(input int num_ble);
        return $clog2(2 * num_ble + 1);
    endfunction

    // element inputs choose from zero, four faces and the block feedback
    function automatic int ble_sel_width(input int num_ble);
        return $clog2((NUM_SIDES + 1) * num_ble + 1);
    endfunction

    // truth table, register enable, then one select per lookup table input
    function automatic int ble_cfg_bits(input int num_ble);
        return LUT_BITS + 1 + LUT_K * ble_sel_width(num_ble);
    endfunction

endpackage

//--- hdl/config_shift_reg.sv
`timescale 1ns/1ps

module config_shift_reg #(
    parameter int LEN = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           config_en,
    input  logic           cfg_in,
    output logic           cfg_out,
    output logic [LEN-1:0] cfg
);

    // new bits enter at the bottom and leave from the top toward the next block
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (config_en) begin
            cfg <= {cfg[LEN-2:0], cfg_in};
        end
    end

    assign cfg_out = cfg[LEN-1];

endmodule

//--- hdl/ble.sv
`timescale 1ns/1ps

module ble import fabric_pkg::*; #(
    parameter int NUM_BLE = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [ble_cfg_bits(NUM_BLE)-1:0]    cfg,
    input  logic [(NUM_SIDES+1)*NUM_BLE-1:0]    sources,
    output logic                                out
);

    localparam int SEL_W = ble_sel_width(NUM_BLE);
    localparam int NUM_SRC = (NUM_SIDES + 1) * NUM_BLE;
    localparam int SEL_BASE = LUT_BITS + 1;

    logic [NUM_SRC:0]    src_ext;
    logic [LUT_K-1:0]    lut_addr;
    logic [LUT_BITS-1:0] truth;
    logic                lut_val;
    logic                lut_q;

    assign src_ext = {sources, 1'b0}; // code 0 reads the constant zero below the sources
    assign truth = cfg[LUT_BITS-1:0];

    for (genvar k = 0; k < LUT_K; k++) begin : g_input
        logic [SEL_W-1:0] sel;

        assign sel = cfg[SEL_BASE + k*SEL_W +: SEL_W];
        assign lut_addr[k] = (sel <= NUM_SRC) ? src_ext[sel] : 1'b0;
    end

    // input 0 drives the low address bit
    assign lut_val = truth[lut_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            lut_q <= 1'b0;
        end else begin
            lut_q <= lut_val;
        end
    end

    assign out = cfg[LUT_BITS] ? lut_q : lut_val;

endmodule

//--- hdl/clb.sv
`timescale 1ns/1ps

module clb import fabric_pkg::*; #(
    parameter int NUM_BLE = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            config_en,
    input  logic                            cfg_in,
    output logic                            cfg_out,
    input  logic [NUM_SIDES*NUM_BLE-1:0]    side_in,
    output logic [NUM_BLE-1:0]              data_out
);

    localparam int BLE_CFG = ble_cfg_bits(NUM_BLE);
    localparam int LEN = NUM_BLE * BLE_CFG;

    logic [LEN-1:0]                     cfg;
    logic [(NUM_SIDES+1)*NUM_BLE-1:0]   sources;

    config_shift_reg #(
        .LEN(LEN)
    ) config_shift_reg_inst (
        .clk(clk),
        .reset(reset),
        .config_en(config_en),
        .cfg_in(cfg_in),
        .cfg_out(cfg_out),
        .cfg(cfg)
    );

    // the block's own outputs follow the four faces so any element can chain off another
    assign sources = {data_out, side_in};

    for (genvar b = 0; b < NUM_BLE; b++) begin : g_ble
        ble #(
            .NUM_BLE(NUM_BLE)
        ) ble_inst (
            .clk(clk),
            .reset(reset),
            .cfg(cfg[b*BLE_CFG +: BLE_CFG]),
            .sources(sources),
            .out(data_out[b])
        );
    end

endmodule

//--- hdl/connector_box.sv
`timescale 1ns/1ps

module connector_box import fabric_pkg::*; #(
    parameter int NUM_BLE = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                config_en,
    input  logic                cfg_in,
    output logic                cfg_out,
    input  logic [NUM_BLE-1:0]  a_in,
    input  logic [NUM_BLE-1:0]  b_in,
    output logic [NUM_BLE-1:0]  a_out,
    output logic [NUM_BLE-1:0]  b_out
);

    localparam int SEL_W = cx_sel_width(NUM_BLE);
    localparam int NUM_SRC = 2 * NUM_BLE;
    localparam int LEN = NUM_SRC * SEL_W;

    logic [LEN-1:0]     cfg;
    logic [NUM_SRC:0]   src_ext;
    logic [NUM_SRC-1:0] outs;

    config_shift_reg #(
        .LEN(LEN)
    ) config_shift_reg_inst (
        .clk(clk),
        .reset(reset),
        .config_en(config_en),
        .cfg_in(cfg_in),
        .cfg_out(cfg_out),
        .cfg(cfg)
    );

    assign src_ext = {b_in, a_in, 1'b0};

    // outputs 0 to NUM_BLE-1 feed side a, the rest feed side b
    for (genvar j = 0; j < NUM_SRC; j++) begin : g_out
        logic [SEL_W-1:0] sel;

        assign sel = cfg[j*SEL_W +: SEL_W];
        assign outs[j] = (sel <= NUM_SRC) ? src_ext[sel] : 1'b0; // spare codes read as zero
    end

    assign a_out = outs[NUM_BLE-1:0];
    assign b_out = outs[NUM_SRC-1:NUM_BLE];

endmodule

//--- hdl/io_block.sv
`timescale 1ns/1ps

module io_block #(
    parameter int NUM_BLE = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                config_en,
    input  logic                cfg_in,
    output logic                cfg_out,
    input  logic [NUM_BLE-1:0]  data_in,
    output logic [NUM_BLE-1:0]  to_fabric,
    input  logic [NUM_BLE-1:0]  from_fabric,
    output logic [NUM_BLE-1:0]  data_out
);

    localparam int LEN = 2 * NUM_BLE;

    logic [LEN-1:0]     cfg;
    logic [NUM_BLE-1:0] in_reg_en;
    logic [NUM_BLE-1:0] out_reg_en;
    logic [NUM_BLE-1:0] in_q;
    logic [NUM_BLE-1:0] out_q;

    config_shift_reg #(
        .LEN(LEN)
    ) config_shift_reg_inst (
        .clk(clk),
        .reset(reset),
        .config_en(config_en),
        .cfg_in(cfg_in),
        .cfg_out(cfg_out),
        .cfg(cfg)
    );

    assign in_reg_en = cfg[NUM_BLE-1:0];
    assign out_reg_en = cfg[LEN-1:NUM_BLE];

    // both pin registers run every cycle, the enables only pick which value is seen
    always_ff @(posedge clk) begin
        if (reset) begin
            in_q <= '0;
            out_q <= '0;
        end else begin
            in_q <= data_in;
            out_q <= from_fabric;
        end
    end

    assign to_fabric = (in_reg_en & in_q) | (~in_reg_en & data_in);
    assign data_out = (out_reg_en & out_q) | (~out_reg_en & from_fabric);

endmodule

//--- hdl/fabric_top.sv
`timescale 1ns/1ps

module fabric_top import fabric_pkg::*; #(
    parameter int MESH_SIZE_X = 2, // at least 2
    parameter int MESH_SIZE_Y = 2, // at least 2
    parameter int NUM_BLE = 3
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            config_en,
    input  logic                                            config_in,
    output logic                                            config_out,
    input  logic [2*(MESH_SIZE_X+MESH_SIZE_Y)*NUM_BLE-1:0]  data_in,
    output logic [2*(MESH_SIZE_X+MESH_SIZE_Y)*NUM_BLE-1:0]  data_out
);

    localparam int NUM_IO = 2 * (MESH_SIZE_X + MESH_SIZE_Y);
    localparam int NUM_HCX = (MESH_SIZE_X + 1) * MESH_SIZE_Y;
    localparam int NUM_VCX = MESH_SIZE_X * (MESH_SIZE_Y + 1);
    localparam int NUM_CLB = MESH_SIZE_X * MESH_SIZE_Y;

    // block positions along the configuration chain
    localparam int HCX_BASE = NUM_IO;
    localparam int VCX_BASE = HCX_BASE + NUM_HCX;
    localparam int CLB_BASE = VCX_BASE + NUM_VCX;
    localparam int NUM_BLOCKS = CLB_BASE + NUM_CLB;

    // I/O block numbering, shared by the chain and the pin slices
    localparam int IO_SIDE_BASE = MESH_SIZE_X;
    localparam int IO_BOTTOM_BASE = MESH_SIZE_X + 2 * MESH_SIZE_Y;

    localparam int CLB_SIDE_W = NUM_SIDES * NUM_BLE;

    wire [NUM_BLOCKS:0]             chain;
    wire [NUM_IO*NUM_BLE-1:0]       io_to_fab;
    wire [NUM_IO*NUM_BLE-1:0]       fab_to_io;
    wire [NUM_CLB*NUM_BLE-1:0]      clb_out;
    wire [NUM_CLB*CLB_SIDE_W-1:0]   clb_in;

    assign chain[0] = config_in;
    assign config_out = chain[NUM_BLOCKS];

    for (genvar i = 0; i < NUM_IO; i++) begin : g_io
        io_block #(
            .NUM_BLE(NUM_BLE)
        ) io_block_inst (
            .clk(clk),
            .reset(reset),
            .config_en(config_en),
            .cfg_in(chain[i]),
            .cfg_out(chain[i+1]),
            .data_in(data_in[i*NUM_BLE +: NUM_BLE]),
            .to_fabric(io_to_fab[i*NUM_BLE +: NUM_BLE]),
            .from_fabric(fab_to_io[i*NUM_BLE +: NUM_BLE]),
            .data_out(data_out[i*NUM_BLE +: NUM_BLE])
        );
    end

    // horizontal boxes sit between blocks of one row, side a looking left
    for (genvar y = 0; y < MESH_SIZE_Y; y++) begin : g_hcx_row
        for (genvar p = 0; p <= MESH_SIZE_X; p++) begin : g_hcx_pos
            localparam int CHAIN_IDX = HCX_BASE + y * (MESH_SIZE_X + 1) + p;

            logic [NUM_BLE-1:0] a_in;
            logic [NUM_BLE-1:0] b_in;
            logic [NUM_BLE-1:0] a_out;
            logic [NUM_BLE-1:0] b_out;

            connector_box #(
                .NUM_BLE(NUM_BLE)
            ) connector_box_inst (
                .clk(clk),
                .reset(reset),
                .config_en(config_en),
                .cfg_in(chain[CHAIN_IDX]),
                .cfg_out(chain[CHAIN_IDX+1]),
                .a_in(a_in),
                .b_in(b_in),
                .a_out(a_out),
                .b_out(b_out)
            );

            if (p == 0) begin : g_a_io
                localparam int IO = IO_SIDE_BASE + 2 * y;
                assign a_in = io_to_fab[IO*NUM_BLE +: NUM_BLE];
                assign fab_to_io[IO*NUM_BLE +: NUM_BLE] = a_out;
            end else begin : g_a_clb
                localparam int C = y * MESH_SIZE_X + p - 1;
                assign a_in = clb_out[C*NUM_BLE +: NUM_BLE];
                assign clb_in[C*CLB_SIDE_W + SIDE_RIGHT*NUM_BLE +: NUM_BLE] = a_out;
            end

            if (p == MESH_SIZE_X) begin : g_b_io
                localparam int IO = IO_SIDE_BASE + 2 * y + 1;
                assign b_in = io_to_fab[IO*NUM_BLE +: NUM_BLE];
                assign fab_to_io[IO*NUM_BLE +: NUM_BLE] = b_out;
            end else begin : g_b_clb
                localparam int C = y * MESH_SIZE_X + p;
                assign b_in = clb_out[C*NUM_BLE +: NUM_BLE];
                assign clb_in[C*CLB_SIDE_W + SIDE_LEFT*NUM_BLE +: NUM_BLE] = b_out;
            end
        end
    end

    // vertical boxes sit between blocks of one column, side a looking up
    for (genvar x = 0; x < MESH_SIZE_X; x++) begin : g_vcx_col
        for (genvar p = 0; p <= MESH_SIZE_Y; p++) begin : g_vcx_pos
            localparam int CHAIN_IDX = VCX_BASE + x * (MESH_SIZE_Y + 1) + p;

            logic [NUM_BLE-1:0] a_in;
            logic [NUM_BLE-1:0] b_in;
            logic [NUM_BLE-1:0] a_out;
            logic [NUM_BLE-1:0] b_out;

            connector_box #(
                .NUM_BLE(NUM_BLE)
            ) connector_box_inst (
                .clk(clk),
                .reset(reset),
                .config_en(config_en),
                .cfg_in(chain[CHAIN_IDX]),
                .cfg_out(chain[CHAIN_IDX+1]),
                .a_in(a_in),
                .b_in(b_in),
                .a_out(a_out),
                .b_out(b_out)
            );

            if (p == 0) begin : g_a_io
                assign a_in = io_to_fab[x*NUM_BLE +: NUM_BLE];
                assign fab_to_io[x*NUM_BLE +: NUM_BLE] = a_out;
            end else begin : g_a_clb
                localparam int C = (p - 1) * MESH_SIZE_X + x;
                assign a_in = clb_out[C*NUM_BLE +: NUM_BLE];
                assign clb_in[C*CLB_SIDE_W + SIDE_BOTTOM*NUM_BLE +: NUM_BLE] = a_out;
            end

            if (p == MESH_SIZE_Y) begin : g_b_io
                localparam int IO = IO_BOTTOM_BASE + x;
                assign b_in = io_to_fab[IO*NUM_BLE +: NUM_BLE];
                assign fab_to_io[IO*NUM_BLE +: NUM_BLE] = b_out;
            end else begin : g_b_clb
                localparam int C = p * MESH_SIZE_X + x;
                assign b_in = clb_out[C*NUM_BLE +: NUM_BLE];
                assign clb_in[C*CLB_SIDE_W + SIDE_TOP*NUM_BLE +: NUM_BLE] = b_out;
            end
        end
    end

    for (genvar y = 0; y < MESH_SIZE_Y; y++) begin : g_clb_row
        for (genvar x = 0; x < MESH_SIZE_X; x++) begin : g_clb_col
            localparam int C = y * MESH_SIZE_X + x; // row-major, same as the chain

            clb #(
                .NUM_BLE(NUM_BLE)
            ) clb_inst (
                .clk(clk),
                .reset(reset),
                .config_en(config_en),
                .cfg_in(chain[CLB_BASE+C]),
                .cfg_out(chain[CLB_BASE+C+1]),
                .side_in(clb_in[C*CLB_SIDE_W +: CLB_SIDE_W]),
                .data_out(clb_out[C*NUM_BLE +: NUM_BLE])
            );
        end
    end

endmodule

//--- tb/tb_bitstream.svh
`ifndef TB_BITSTREAM_SVH
`define TB_BITSTREAM_SVH

// chain offsets follow the block order io, horizontal boxes, vertical boxes, logic blocks
function automatic int io_offset(input int i);
    return i * IO_BITS;
endfunction

function automatic int vcx_offset(input int x, input int p);
    return NUM_IO * IO_BITS + NUM_HCX * CX_BITS + (x * (MESH_Y + 1) + p) * CX_BITS;
endfunction

function automatic int clb_offset(input int c);
    return NUM_IO * IO_BITS + (NUM_HCX + NUM_VCX) * CX_BITS + c * CLB_BITS;
endfunction

// writes the low w bits of val into the image starting at off
function automatic logic [CHAIN_LEN-1:0] put_bits(input logic [CHAIN_LEN-1:0] img,
                                                  input int off, input int w, input int val);
    logic [CHAIN_LEN-1:0] res;
    res = img;
    for (int b = 0; b < w; b++) begin
        res[IW'(off + b)] = 1'((val >> b) & 1);
    end
    return res;
endfunction

// route the top-left io pins down into block (0,0), xor three of them, send it back up
function automatic logic [CHAIN_LEN-1:0] build_image(input logic registered);
    logic [CHAIN_LEN-1:0] img;
    int vo;
    int co;
    img = '0;
    vo = vcx_offset(0, 0);
    co = clb_offset(0);
    if (registered) begin
        img = put_bits(img, io_offset(0), NUM_BLE, (1 << NUM_BLE) - 1); // inbound registers
        img = put_bits(img, io_offset(0) + NUM_BLE, 1, 1); // outbound register of pin 0
    end
    img = put_bits(img, vo, CXW, NUM_BLE + 1); // a_out pin 0 takes b_in pin 0
    for (int i = 0; i < NUM_BLE; i++) begin
        img = put_bits(img, vo + (NUM_BLE + i) * CXW, CXW, 1 + i); // b_out pin i takes a_in pin i
    end
    img = put_bits(img, co, LUT_BITS, 16'h9696); // parity of the three low address bits
    img = put_bits(img, co + LUT_BITS, 1, int'(registered));
    for (int k = 0; k < 3; k++) begin
        img = put_bits(img, co + LUT_BITS + 1 + k * BSW, BSW, 1 + SIDE_TOP * NUM_BLE + k);
    end
    return img;
endfunction

// expected value of the routed path
function automatic logic xor_ref(input logic [2:0] pins);
    return pins[0] ^ pins[1] ^ pins[2];
endfunction

`endif

//--- tb/tb_fabric_top.sv
`timescale 1ns/1ps

module tb_fabric_top import fabric_pkg::*; ;

    localparam int MESH_X = 2;
    localparam int MESH_Y = 2;
    localparam int NUM_BLE = 3;
    localparam int NUM_IO = 2 * (MESH_X + MESH_Y);
    localparam int NUM_HCX = (MESH_X + 1) * MESH_Y;
    localparam int NUM_VCX = MESH_X * (MESH_Y + 1);
    localparam int CXW = cx_sel_width(NUM_BLE);
    localparam int BSW = ble_sel_width(NUM_BLE);
    localparam int IO_BITS = 2 * NUM_BLE;
    localparam int CX_BITS = 2 * NUM_BLE * CXW;
    localparam int CLB_BITS = NUM_BLE * ble_cfg_bits(NUM_BLE);
    localparam int CHAIN_LEN = NUM_IO * IO_BITS + (NUM_HCX + NUM_VCX) * CX_BITS
                               + MESH_X * MESH_Y * CLB_BITS;
    localparam int IW = $clog2(CHAIN_LEN);
    localparam int PINS = NUM_IO * NUM_BLE;
    localparam int HIST_LEN = 4096;

    `include "tb_bitstream.svh"

    logic            clk = 1'b0;
    logic            reset;
    logic            config_en;
    logic            config_in;
    logic            config_out;
    logic [PINS-1:0] data_in;
    logic [PINS-1:0] data_out;

    logic       chk_zero;
    logic       chk_chain;
    logic       chk_comb;
    logic       chk_pipe;
    int         errors = 0;
    int         checks = 0;
    logic [31:0] rng = 32'hb17d;

    logic       hist [0:HIST_LEN-1]; // every bit the chain has taken since reset
    int         nshift;
    logic       exp_cfg_out;

    fabric_top #(
        .MESH_SIZE_X(MESH_X),
        .MESH_SIZE_Y(MESH_Y),
        .NUM_BLE(NUM_BLE)
    ) fabric_top_inst (
        .clk(clk),
        .reset(reset),
        .config_en(config_en),
        .config_in(config_in),
        .config_out(config_out),
        .data_in(data_in),
        .data_out(data_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            nshift <= 0;
        end else if (config_en) begin
            if (nshift < HIST_LEN) hist[12'(nshift)] <= config_in;
            nshift <= nshift + 1;
        end
    end

    // a bit taken at shift n leaves the chain once CHAIN_LEN shifts have happened
    assign exp_cfg_out = (nshift >= CHAIN_LEN && nshift - CHAIN_LEN < HIST_LEN) ?
                         hist[12'(nshift - CHAIN_LEN)] : 1'b0;

    always @(posedge clk) begin
        if (chk_zero || chk_chain || chk_comb || chk_pipe) checks <= checks + 1;
    end

    a_zero: assert property (@(posedge clk) !chk_zero || (data_out == '0 && !config_out))
        else begin
            errors = errors + 1;
            $display("error data_out: got %h expected 0, config_out %h",
                     $sampled(data_out), $sampled(config_out));
        end

    a_chain: assert property (@(posedge clk) !chk_chain || config_out == exp_cfg_out)
        else begin
            errors = errors + 1;
            $display("error config_out: got %h expected %h",
                     $sampled(config_out), $sampled(exp_cfg_out));
        end

    a_comb: assert property (@(posedge clk) !chk_comb || data_out[0] == xor_ref(data_in[2:0]))
        else begin
            errors = errors + 1;
            $display("error data_out[0]: got %h expected %h",
                     $sampled(data_out[0]), xor_ref($sampled(data_in[2:0])));
        end

    a_pipe: assert property (@(posedge clk)
                             !chk_pipe || data_out[0] == xor_ref($past(data_in[2:0], 3)))
        else begin
            errors = errors + 1;
            $display("error data_out[0]: got %h expected %h",
                     $sampled(data_out[0]), xor_ref($past(data_in[2:0], 3)));
        end

    // pins outside the route stay quiet
    a_quiet: assert property (@(posedge clk) !(chk_comb || chk_pipe) || data_out[PINS-1:1] == '0)
        else begin
            errors = errors + 1;
            $display("error data_out[%0d:1]: got %h expected 0", PINS - 1,
                     $sampled(data_out[PINS-1:1]));
        end

    function automatic logic [31:0] rand_word();
        logic [31:0] s;
        s = rng;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng = s;
        return s;
    endfunction

    task automatic shift_bit(input logic b);
        @(posedge clk);
        config_en <= 1'b1;
        config_in <= b;
    endtask

    // top bit goes in first so bit 0 ends up in the first io block
    task automatic load_image(input logic [CHAIN_LEN-1:0] img);
        for (int i = CHAIN_LEN - 1; i >= 0; i--) begin
            shift_bit(img[IW'(i)]);
        end
        @(posedge clk);
        config_en <= 1'b0;
    endtask

    // a clean chain keeps a partly shifted image from closing a loop through the fabric
    task automatic clear_fabric();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic drive_data(input logic toggle_cfg);
        logic [31:0] w;
        w = rand_word();
        @(posedge clk);
        data_in <= w[PINS-1:0];
        if (toggle_cfg) config_in <= w[31]; // chain must ignore this while disabled
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((data_out !== '0 || config_out !== 1'b0) && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (n >= 20) begin
            errors = errors + 1;
            $display("outputs did not settle to zero after reset");
        end
    endtask

    initial begin
        #2000000;
        $display("simulation timed out");
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] w;
        reset = 1'b1;
        config_en = 1'b0;
        config_in = 1'b0;
        data_in = '0;
        chk_zero = 1'b0;
        chk_chain = 1'b0;
        chk_comb = 1'b0;
        chk_pipe = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait_idle();

        @(posedge clk);
        chk_zero <= 1'b1;
        chk_chain <= 1'b1;
        repeat (10) drive_data(1'b1);
        @(posedge clk);
        chk_zero <= 1'b0;

        // ones stay 40 shifts apart so no element slice ever holds two set bits
        // and the random contents cannot form an oscillating loop
        for (int i = 0; i < CHAIN_LEN + 64; i++) begin
            w = rand_word();
            shift_bit(w[7] && (i % 40 == 0));
        end
        @(posedge clk);
        config_en <= 1'b0;
        repeat (160) drive_data(1'b1); // config_out must hold while config_in keeps toggling

        clear_fabric();
        load_image(build_image(1'b0));
        @(posedge clk);
        chk_comb <= 1'b1;
        repeat (64) drive_data(1'b1);
        @(posedge clk);
        chk_comb <= 1'b0;

        clear_fabric();
        load_image(build_image(1'b1));
        repeat (3) drive_data(1'b0);
        chk_pipe <= 1'b1; // first checked sample sees three edges of fresh data
        repeat (64) drive_data(1'b0);
        @(posedge clk);
        chk_pipe <= 1'b0;
        repeat (4) @(posedge clk);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+tb
hdl/fabric_pkg.sv
hdl/config_shift_reg.sv
hdl/ble.sv
hdl/clb.sv
hdl/connector_box.sv
hdl/io_block.sv
hdl/fabric_top.sv
tb/tb_fabric_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run with Verilator, then decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-UNOPTFLAT -f src.f \
    --top-module tb_fabric_top -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log
test -s sim.log || { echo "simulation did not run"; exit 1; }
grep -q "Errors found" sim.log && exit 1 || exit 0
